// ==== hdl/bufferTerm.sv ====
/*
 Data buffer enables and directions, registered TACKn
*/
`default_nettype none

module bufferTerm (
    input  logic CLK80,
    input  logic RESETn,
    input  logic RnW,
    input  logic AWEn,
    input  logic cpuCycle,
    input  logic dmaCycle,
    input  logic regCycleOn,
    input  logic cpuTack,
    input  logic regTack,
    output logic DBENn,
    output logic DBDIR,
    output logic VBENn,
    output logic DRDENn,
    output logic DRDDIR,
    output logic TACKn
);

    // Local bus to chip RAM, high toward the CPU on reads
    assign DBENn = ~cpuCycle;
    assign DBDIR = cpuCycle & RnW;

    // Register bus buffer
    assign VBENn = ~regCycleOn;

    // Agnus data path, direction from AWEn
    assign DRDENn = ~dmaCycle;
    assign DRDDIR = AWEn | ~dmaCycle;

    ////////////////////
    // One clock after either source
    always_ff @(posedge CLK80) begin
        if (!RESETn) begin
            TACKn <= 1'b1;
        end else begin
            TACKn <= ~(cpuTack | regTack);
        end
    end

endmodule

`default_nettype wire

// ==== hdl/byteLanes.sv ====
/*
 Chip RAM byte enables and register bus UDS/LDS
*/
`default_nettype none

module byteLanes (
    input  logic       cpuCycle,
    input  logic       dmaCycle,
    input  logic       dsEn,
    input  logic       CASLn,
    input  logic       CASUn,
    input  logic [1:0] SIZ,
    input  logic [1:0] A,
    output logic       CUUBEn,
    output logic       CUMBEn,
    output logic       CLMBEn,
    output logic       CLLBEn,
    output logic       UDSn,
    output logic       LDSn
);

    // Active high lanes, bit 3 is the uppermost byte
    logic [3:0] cpuLanes;
    logic [3:0] laneOn;
    logic       wideReg;

    always_comb begin
        case (SIZ)
            chipBusPkg::SIZE_BYTE: cpuLanes = 4'b1000 >> A;
            chipBusPkg::SIZE_WORD: cpuLanes = A[1] ? 4'b0011 : 4'b1100;
            chipBusPkg::SIZE_LONG,
            chipBusPkg::SIZE_LINE: cpuLanes = 4'b1111;
            default:               cpuLanes = 4'b1111;
        endcase
    end

    // Agnus is 16 bits wide, on the low half
    always_comb begin
        if (cpuCycle) begin
            laneOn = cpuLanes;
        end else if (dmaCycle) begin
            laneOn = {2'b00, ~CASUn, ~CASLn};
        end else begin
            laneOn = 4'b0000;
        end
    end

    assign {CUUBEn, CUMBEn, CLMBEn, CLLBEn} = ~laneOn;

    ////////////////////
    // Register bus strobes, all non-byte sizes drive both
    assign wideReg = (SIZ != chipBusPkg::SIZE_BYTE);
    assign UDSn    = ~(dsEn & (wideReg | ~A[0]));
    assign LDSn    = ~(dsEn & (wideReg | A[0]));

endmodule

`default_nettype wire

// ==== hdl/chipBusPkg.sv ====
/*
 Chip RAM bridge shared constants
 SDRAM timing, CPU address fields, SIZ codes and sequencer states
*/
`default_nettype none

package chipBusPkg;

    ////////////////////
    // SDRAM timing, in CLK80 cycles
    // ACTIVE to READ/WRITE
    localparam int TRCD = 2;
    // Precharge to idle
    localparam int TRP = 2;

    // Flops per Agnus input synchronizer
    localparam int SYNC_STAGES = 2;

    ////////////////////
    // 68040 SIZ encodings
    localparam logic [1:0] SIZE_LONG = 2'b00;
    localparam logic [1:0] SIZE_BYTE = 2'b01;
    localparam logic [1:0] SIZE_WORD = 2'b10;
    // Line transfers run as longwords
    localparam logic [1:0] SIZE_LINE = 2'b11;

    ////////////////////
    // CPU address fields
    // A[9:2] column, A[18:10] row, A[20:19] bank
    localparam int COL_LSB   = 2;
    localparam int COL_WIDTH = 8;
    localparam int ROW_LSB   = 10;
    localparam int ROW_WIDTH = 9;
    localparam int BANK_LSB  = 19;

    // SDRAM sequencer states
    localparam logic [1:0] SEQ_IDLE   = 2'd0;
    localparam logic [1:0] SEQ_ACTIVE = 2'd1;
    localparam logic [1:0] SEQ_RW     = 2'd2;
    localparam logic [1:0] SEQ_PRE    = 2'd3;

    // A10 high selects all banks on PRECHARGE
    localparam logic [10:0] CMA_PRE_ALL = 11'h400;

endpackage

`default_nettype wire

// ==== hdl/chipBusTop.sv ====
/*
 Chip RAM bridge glue between the 68040 local bus and Agnus
 Arbiter, SDRAM sequencer, register cycle, byte lanes and bus buffers
*/
`default_nettype none

module chipBusTop (
    input  logic        CLK80,
    input  logic        RESETn,
    input  logic        C1,
    input  logic        C3,
    input  logic        RnW,
    input  logic        TSn,
    input  logic        DBRn,
    input  logic        REGSPACEn,
    input  logic        RAMSPACEn,
    input  logic        AWEn,
    input  logic        RAS0n,
    input  logic        RAS1n,
    input  logic        CASLn,
    input  logic        CASUn,
    input  logic [1:0]  SIZ,
    input  logic [20:0] A,
    input  logic [9:0]  DRA,

    output logic        LDSn, UDSn, ASn, REGENn, DBDIR,
    output logic        VBENn, DRDENn, DRDDIR,
    output logic        CRCSn, BANK1, BANK0, RASn, CASn, WEn, DBENn,
    output logic        CUUBEn, CUMBEn, CLMBEn, CLLBEn,
    output logic        TACKn,
    output logic [10:0] CMA
);

    // Arbiter to sequencer handshake
    logic       grantCpu;
    logic       grantDma;
    logic       ramIdle;
    logic [1:0] dmaBank;
    // Synchronized DMA request, holds off register cycles
    logic       dmaPending;

    // Cycle type levels and terminations
    logic       cpuCycle;
    logic       dmaCycle;
    logic       cpuTack;
    logic       regCycleOn;
    logic       regTack;
    logic       dsEn;

    ////////////////////
    // Chip RAM ownership
    chipRamArbiter chipRamArbiter_i (
        .CLK80, .RESETn, .TSn, .RAMSPACEn, .DBRn,
        .RAS0n, .RAS1n, .CASLn, .CASUn, .ramIdle,
        .grantCpu, .grantDma, .dmaPending, .dmaBank
    );

    // SDRAM commands and CMA mux
    chipRamSeq chipRamSeq_i (
        .CLK80, .RESETn, .grantCpu, .grantDma, .dmaBank,
        .RnW, .AWEn, .A(A[20:2]), .DRA, .CASLn, .CASUn,
        .ramIdle, .cpuCycle, .dmaCycle, .cpuTack,
        .CRCSn, .RASn, .CASn, .WEn, .BANK1, .BANK0, .CMA
    );

    ////////////////////
    // Agnus register bus, 68000 style
    regCycle regCycle_i (
        .CLK80, .RESETn, .C1, .C3, .TSn, .REGSPACEn, .dmaPending,
        .ASn, .REGENn, .dsEn, .regCycleOn, .regTack
    );

    // Lane enables for RAM and data strobes for registers
    byteLanes byteLanes_i (
        .cpuCycle, .dmaCycle, .dsEn, .CASLn, .CASUn, .SIZ, .A(A[1:0]),
        .CUUBEn, .CUMBEn, .CLMBEn, .CLLBEn, .UDSn, .LDSn
    );

    // Buffers and TACKn
    bufferTerm bufferTerm_i (
        .CLK80, .RESETn, .RnW, .AWEn,
        .cpuCycle, .dmaCycle, .regCycleOn, .cpuTack, .regTack,
        .DBENn, .DBDIR, .VBENn, .DRDENn, .DRDDIR, .TACKn
    );

endmodule

`default_nettype wire

// ==== hdl/chipRamArbiter.sv ====
/*
 Chip RAM arbiter, Agnus DMA ahead of the CPU
 Syncs DBRn and the RAS/CAS strobes, holds the CPU request
*/
`default_nettype none

module chipRamArbiter (
    input  logic       CLK80,
    input  logic       RESETn,
    input  logic       TSn,
    input  logic       RAMSPACEn,
    input  logic       DBRn,
    input  logic       RAS0n,
    input  logic       RAS1n,
    input  logic       CASLn,
    input  logic       CASUn,
    input  logic       ramIdle,
    output logic       grantCpu,
    output logic       grantDma,
    output logic       dmaPending,
    output logic [1:0] dmaBank
);

    // {DBRn, RAS1n, RAS0n, CASUn, CASLn}
    logic [4:0] agnusIn;
    logic [chipBusPkg::SYNC_STAGES-1:0][4:0] syncPipe;
    logic [4:0] agnusNow;
    logic [4:0] agnusPrev;

    logic ras0Fall;
    logic ras1Fall;
    logic casFall;
    logic cpuTake;
    logic grantFree;

    // Arbiter state
    logic cpuReq;
    logic rasSeen;
    logic dmaReady;

    assign agnusIn  = {DBRn, RAS1n, RAS0n, CASUn, CASLn};
    assign agnusNow = syncPipe[chipBusPkg::SYNC_STAGES-1];

    // Falling edges after the sync chain
    assign ras1Fall = agnusPrev[3] & ~agnusNow[3];
    assign ras0Fall = agnusPrev[2] & ~agnusNow[2];
    assign casFall  = (agnusPrev[1] & ~agnusNow[1]) | (agnusPrev[0] & ~agnusNow[0]);

    // Agnus owns the bus or has an access in flight
    assign dmaPending = ~agnusNow[4] | rasSeen | dmaReady;

    // New CPU RAM request, ignored while one waits
    assign cpuTake = ~TSn & ~RAMSPACEn & ~cpuReq;
    // No grant while the previous one is still in flight
    assign grantFree = ramIdle & ~grantCpu & ~grantDma;

    ////////////////////
    always_ff @(posedge CLK80) begin
        if (!RESETn) begin
            syncPipe  <= '1;
            agnusPrev <= '1;
            cpuReq    <= 1'b0;
            rasSeen   <= 1'b0;
            dmaReady  <= 1'b0;
            grantCpu  <= 1'b0;
            grantDma  <= 1'b0;
        end else begin
            syncPipe  <= {syncPipe[chipBusPkg::SYNC_STAGES-2:0], agnusIn};
            agnusPrev <= agnusNow;
            // Grants are single cycle strobes
            grantCpu  <= 1'b0;
            grantDma  <= 1'b0;

            if (cpuTake) begin
                cpuReq <= 1'b1;
            end

            // RAS opens a DMA access, CAS makes it ready
            if (ras0Fall || ras1Fall) begin
                rasSeen <= 1'b1;
            end
            if (rasSeen && casFall) begin
                rasSeen  <= 1'b0;
                dmaReady <= 1'b1;
            end

            // DMA first, CPU waits out a half-opened DMA access too
            if (grantFree && dmaReady) begin
                grantDma <= 1'b1;
                dmaReady <= 1'b0;
            end else if (grantFree && cpuReq && !rasSeen) begin
                grantCpu <= 1'b1;
                cpuReq   <= 1'b0;
            end
        end
    end

    // Bank from whichever RAS fell
    always_ff @(posedge CLK80) begin
        if (ras1Fall) begin
            dmaBank <= 2'b01;
        end else if (ras0Fall) begin
            dmaBank <= 2'b00;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/chipRamSeq.sv ====
/*
 SDRAM command sequencer for chip RAM
 ACTIVE, TRCD wait, READ/WRITE, then TRP precharge for CPU or DMA
*/
`default_nettype none

module chipRamSeq (
    input  logic        CLK80,
    input  logic        RESETn,
    input  logic        grantCpu,
    input  logic        grantDma,
    input  logic [1:0]  dmaBank,
    input  logic        RnW,
    input  logic        AWEn,
    input  logic [20:2] A,
    input  logic [9:0]  DRA,
    input  logic        CASLn,
    input  logic        CASUn,
    output logic        ramIdle,
    output logic        cpuCycle,
    output logic        dmaCycle,
    output logic        cpuTack,
    output logic        CRCSn,
    output logic        RASn,
    output logic        CASn,
    output logic        WEn,
    output logic        BANK1,
    output logic        BANK0,
    output logic [10:0] CMA
);

    logic [1:0] state;
    logic [1:0] waitCnt;
    logic       isCpu;

    // Agnus address capture
    logic       casLow;
    logic       casLowQ;
    logic       casStart;
    logic       dmaHold;
    logic [9:0] dmaRow;
    logic [9:0] dmaCol;
    logic [9:0] colLatch;

    logic       startAct;
    logic       issueRw;
    logic       issuePre;

    assign ramIdle  = (state == chipBusPkg::SEQ_IDLE);
    assign startAct = ramIdle & (grantCpu | grantDma);
    assign issueRw  = (state == chipBusPkg::SEQ_ACTIVE) & (waitCnt == 2'd0);
    assign issuePre = (state == chipBusPkg::SEQ_RW);

    // First CAS of an Agnus access
    assign casLow   = ~CASLn | ~CASUn;
    assign casStart = casLow & ~casLowQ & ~dmaHold;

    ////////////////////
    // Address path
    always_ff @(posedge CLK80) begin
        // Agnus keeps the row on DRA until it drops CAS
        if (!casLow && !dmaHold) begin
            dmaRow <= DRA;
        end
        if (casStart) begin
            dmaCol <= DRA;
        end

        if (startAct) begin
            if (grantCpu) begin
                CMA      <= 11'(A[chipBusPkg::ROW_LSB +: chipBusPkg::ROW_WIDTH]);
                colLatch <= 10'(A[chipBusPkg::COL_LSB +: chipBusPkg::COL_WIDTH]);
                {BANK1, BANK0} <= A[chipBusPkg::BANK_LSB +: 2];
            end else begin
                CMA      <= 11'(dmaRow);
                colLatch <= dmaCol;
                {BANK1, BANK0} <= dmaBank;
            end
        end else if (issueRw) begin
            CMA <= 11'(colLatch);
        end else if (issuePre) begin
            CMA <= chipBusPkg::CMA_PRE_ALL;
        end
    end

    ////////////////////
    // Command FSM
    always_ff @(posedge CLK80) begin
        if (!RESETn) begin
            state    <= chipBusPkg::SEQ_IDLE;
            waitCnt  <= 2'd0;
            isCpu    <= 1'b0;
            cpuCycle <= 1'b0;
            dmaCycle <= 1'b0;
            cpuTack  <= 1'b0;
            CRCSn    <= 1'b1;
            RASn     <= 1'b1;
            CASn     <= 1'b1;
            WEn      <= 1'b1;
            casLowQ  <= 1'b0;
            dmaHold  <= 1'b0;
        end else begin
            cpuTack <= 1'b0;
            casLowQ <= casLow;

            // Column held until its access is granted
            if (grantDma) begin
                dmaHold <= 1'b0;
            end
            if (casStart) begin
                dmaHold <= 1'b1;
            end

            case (state)
                chipBusPkg::SEQ_IDLE: begin
                    if (startAct) begin
                        state    <= chipBusPkg::SEQ_ACTIVE;
                        waitCnt  <= 2'(chipBusPkg::TRCD - 1);
                        isCpu    <= grantCpu;
                        cpuCycle <= grantCpu;
                        dmaCycle <= grantDma;
                        // ACTIVE
                        CRCSn    <= 1'b0;
                        RASn     <= 1'b0;
                    end
                end
                chipBusPkg::SEQ_ACTIVE: begin
                    RASn <= 1'b1;
                    if (issueRw) begin
                        // READ or WRITE
                        state <= chipBusPkg::SEQ_RW;
                        CASn  <= 1'b0;
                        WEn   <= isCpu ? RnW : AWEn;
                    end else begin
                        waitCnt <= waitCnt - 2'd1;
                    end
                end
                chipBusPkg::SEQ_RW: begin
                    // PRECHARGE all banks
                    state   <= chipBusPkg::SEQ_PRE;
                    waitCnt <= 2'(chipBusPkg::TRP - 1);
                    CASn    <= 1'b1;
                    RASn    <= 1'b0;
                    WEn     <= 1'b0;
                    // CPU data is valid one cycle after CAS
                    cpuTack <= isCpu;
                end
                default: begin
                    RASn <= 1'b1;
                    WEn  <= 1'b1;
                    if (waitCnt == 2'd0) begin
                        state    <= chipBusPkg::SEQ_IDLE;
                        cpuCycle <= 1'b0;
                        dmaCycle <= 1'b0;
                        CRCSn    <= 1'b1;
                    end else begin
                        waitCnt <= waitCnt - 2'd1;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/regCycle.sv ====
/*
 Agnus register bus cycle, 68000 style
 AS and REGEN framed between two rising C3 edges
*/
`default_nettype none

module regCycle (
    input  logic CLK80,
    input  logic RESETn,
    input  logic C1,
    input  logic C3,
    input  logic TSn,
    input  logic REGSPACEn,
    input  logic dmaPending,
    output logic ASn,
    output logic REGENn,
    output logic dsEn,
    output logic regCycleOn,
    output logic regTack
);

    // {C3, C1} sync chain
    logic [chipBusPkg::SYNC_STAGES-1:0][1:0] clkSync;
    logic c1Now;
    logic c3Now;
    logic c3Prev;
    logic c3Rise;

    logic reqPend;
    logic busOn;
    logic dsDly;

    assign c1Now = clkSync[chipBusPkg::SYNC_STAGES-1][0];
    assign c3Now = clkSync[chipBusPkg::SYNC_STAGES-1][1];

    // C3 lags C1 by a quarter, so a real C3 rise lands in C1 high
    assign c3Rise = c3Now & ~c3Prev & c1Now;

    // Address and enable share one frame
    assign ASn        = ~busOn;
    assign REGENn     = ~busOn;
    assign regCycleOn = busOn;
    // Data strobes one clock behind AS
    assign dsEn       = busOn & dsDly;

    ////////////////////
    always_ff @(posedge CLK80) begin
        if (!RESETn) begin
            clkSync <= '0;
            c3Prev  <= 1'b0;
            reqPend <= 1'b0;
            busOn   <= 1'b0;
            dsDly   <= 1'b0;
            regTack <= 1'b0;
        end else begin
            clkSync <= {clkSync[chipBusPkg::SYNC_STAGES-2:0], {C3, C1}};
            c3Prev  <= c3Now;
            dsDly   <= busOn;
            regTack <= 1'b0;

            // Register request waits here
            if (!TSn && !REGSPACEn && !reqPend) begin
                reqPend <= 1'b1;
            end

            if (c3Rise) begin
                if (busOn) begin
                    // End of frame, terminate the CPU
                    busOn   <= 1'b0;
                    regTack <= 1'b1;
                    reqPend <= 1'b0;
                end else if (reqPend && !dmaPending) begin
                    busOn <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== list.f ====
hdl/chipBusPkg.sv
hdl/chipRamArbiter.sv
hdl/chipRamSeq.sv
hdl/regCycle.sv
hdl/byteLanes.sv
hdl/bufferTerm.sv
hdl/chipBusTop.sv
sim/chipBusChk.sv
sim/tbChipBus.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the chip RAM bridge testbench with Verilator
verilator --binary --timing --assert --top-module tbChipBus -f list.f -o simChipBus \
    > build.log 2>&1 || { cat build.log; echo "BUILD ERROR"; exit 1; }
./obj_dir/simChipBus > sim.log 2>&1
cat sim.log
grep -qx "all tests passed" sim.log && echo "RESULT: PASS" || { echo "RESULT: FAIL"; exit 1; }

// ==== sim/chipBusCases.txt ====
// kind(0 rd,1 wr,2 reg,3 dma,4 collision) addr siz wr draRow draCol
// expRow expCol bank lanes{CUUB,CUMB,CLMB,CLLB} strobes({UDSn,LDSn} or {CASUn,CASLn})
0 1694F0 0 0 000 000 1A5 3C 2 0 0
1 0BC294 0 1 000 000 0F0 A5 1 0 0
0 004488 1 0 000 000 011 22 0 7 0
1 004489 1 1 000 000 011 22 0 B 0
0 00448A 1 0 000 000 011 22 0 D 0
1 00448B 1 1 000 000 011 22 0 E 0
0 00448C 2 0 000 000 011 23 0 3 0
1 00448E 2 1 000 000 011 23 0 C 0
0 1FFFFC 3 0 000 000 1FF FF 3 0 0
1 180004 0 1 000 000 000 01 3 0 0
3 000000 0 0 2AB 155 2AB 155 0 C 0
3 000000 0 1 3FF 001 3FF 001 1 E 2
3 000000 0 0 100 0FE 100 0FE 0 D 1
2 000100 2 0 000 000 000 00 0 0 0
2 000100 1 0 000 000 000 00 0 0 1
2 000101 1 1 000 000 000 00 0 0 2
2 000102 0 0 000 000 000 00 0 0 0
4 0BC294 0 0 2AB 155 0F0 A5 1 0 0
4 1694F0 0 1 010 020 1A5 3C 2 0 0

// ==== sim/chipBusChk.sv ====
/*
 Bus protocol checks bound into the chip RAM bridge top
*/
`default_nettype none

module chipBusChk (
    input logic CLK80,
    input logic RESETn,
    input logic TACKn,
    input logic cpuCycle,
    input logic dmaCycle,
    input logic ASn,
    input logic REGENn
);

    // Termination is a single clock
    tackSingle: assert property (@(posedge CLK80) disable iff (!RESETn) !TACKn |=> TACKn)
        else $error("TACKn low for two cycles in a row");

    // One RAM owner at a time
    ownerOne: assert property (@(posedge CLK80) disable iff (!RESETn) !(cpuCycle && dmaCycle))
        else $error("cpuCycle and dmaCycle high together");

    // Same frame on both pins
    asRegen: assert property (@(posedge CLK80) disable iff (!RESETn) ASn == REGENn)
        else $error("ASn and REGENn differ");

endmodule

bind chipBusTop chipBusChk chipBusChk_i (
    .CLK80,
    .RESETn,
    .TACKn,
    .cpuCycle,
    .dmaCycle,
    .ASn,
    .REGENn
);

`default_nettype wire

// ==== sim/tbChipBus.sv ====
/*
 Testbench for the chip RAM bridge
 Replays the case file through CPU, register, DMA and collision accesses
*/
`default_nettype none

module tbChipBus;

    logic        CLK80;
    logic        RESETn;
    logic        C1;
    logic        C3;
    logic        RnW;
    logic        TSn;
    logic        DBRn;
    logic        REGSPACEn;
    logic        RAMSPACEn;
    logic        AWEn;
    logic        RAS0n;
    logic        RAS1n;
    logic        CASLn;
    logic        CASUn;
    logic [1:0]  SIZ;
    logic [20:0] A;
    logic [9:0]  DRA;
    logic        LDSn, UDSn, ASn, REGENn, DBDIR, VBENn, DRDENn, DRDDIR;
    logic        CRCSn, BANK1, BANK0, RASn, CASn, WEn, DBENn;
    logic        CUUBEn, CUMBEn, CLMBEn, CLLBEn, TACKn;
    logic [10:0] CMA;

    // Eleven hex fields per case line
    logic [31:0] caseMem [0:351];
    logic [2:0]  colCnt = 3'd0;

    // Current case fields
    logic [3:0]  kind;
    logic [20:0] addr;
    logic [1:0]  siz;
    logic        wr;
    logic [9:0]  draRow;
    logic [9:0]  draCol;
    logic [10:0] expRow;
    logic [10:0] expCol;
    logic [1:0]  expBank;
    logic [3:0]  expLanes;
    logic [1:0]  expStrobes;

    // What the RAM watcher saw
    logic        rowSeen, colSeen, weAtCas, dirAtCas, dmaBefore;
    logic [10:0] rowVal, colVal;
    logic [1:0]  bankVal;
    logic [3:0]  lanesAtCas;
    int          tackCount, tackAt;

    int          testNum, testErr, totalErr, testsRun;

    chipBusTop chipBusTop_i (.*);

    initial begin
        CLK80 = 1'b0;
        forever #50 CLK80 = ~CLK80;
    end

    // Colour clocks, 8 CLK80 per period, C3 a quarter behind C1
    always @(posedge CLK80) begin
        colCnt <= colCnt + 3'd1;
    end
    assign C1 = colCnt[2];
    assign C3 = colCnt - 3'd2 >= 3'd4;

    ////////////////////
    task automatic noteFailure();
        testErr  = testErr + 1;
        totalErr = totalErr + 1;
    endtask

    task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] test %0d %s: got %h expected %h", testNum, name, got, exp);
            noteFailure();
        end
    endtask

    // All outputs that rest high when nothing runs
    task automatic checkIdle(input int cycles);
        int n;
        for (n = 0; n < cycles; n++) begin
            @(negedge CLK80);
            checkVal("{RASn,CASn,WEn,CRCSn,TACKn,ASn,REGENn,UDSn,LDSn,VBENn,DRDENn,DBENn,BE}",
                     32'({RASn, CASn, WEn, CRCSn, TACKn, ASn, REGENn, UDSn, LDSn, VBENn,
                          DRDENn, DBENn, CUUBEn, CUMBEn, CLMBEn, CLLBEn}), 32'hFFFF);
        end
    endtask

    // One TSn strobe, sampled by the DUT at the second edge
    task automatic cpuStrobe(input logic isReg);
        @(posedge CLK80);
        A   <= addr;
        SIZ <= siz;
        RnW <= ~wr;
        TSn <= 1'b0;
        if (isReg) begin
            REGSPACEn <= 1'b0;
        end else begin
            RAMSPACEn <= 1'b0;
        end
        @(posedge CLK80);
        TSn       <= 1'b1;
        REGSPACEn <= 1'b1;
        RAMSPACEn <= 1'b1;
    endtask

    // Agnus access, row on RAS then column on CAS
    task automatic agnusAccess(input logic [1:0] bank, input logic [1:0] strobes);
        @(posedge CLK80);
        DBRn <= 1'b0;
        DRA  <= draRow;
        AWEn <= ~wr;
        if (bank[0]) begin
            RAS1n <= 1'b0;
        end else begin
            RAS0n <= 1'b0;
        end
        repeat (3) @(posedge CLK80);
        DRA   <= draCol;
        CASUn <= strobes[1];
        CASLn <= strobes[0];
        repeat (10) @(posedge CLK80);
        RAS0n <= 1'b1;
        RAS1n <= 1'b1;
        CASUn <= 1'b1;
        CASLn <= 1'b1;
        DBRn  <= 1'b1;
        AWEn  <= 1'b1;
    endtask

    ////////////////////
    // Follows one CPU or DMA access through ACTIVE, column and precharge
    task automatic watchRam(input logic cpuSide, input int limit);
        int   n;
        int   tail;
        logic en;
        logic rasPrev;
        logic casPrev;
        logic sawDma;
        rowSeen   = 1'b0;
        colSeen   = 1'b0;
        dmaBefore = 1'b0;
        sawDma    = 1'b0;
        tackCount = 0;
        tackAt    = -1;
        tail      = -1;
        rasPrev   = 1'b1;
        casPrev   = 1'b1;
        n = 0;
        while (tail != 0 && n < limit) begin
            @(negedge CLK80);
            n++;
            en = cpuSide ? ~DBENn : ~DRDENn;
            if (!DRDENn) begin
                sawDma = 1'b1;
            end
            if (!TACKn) begin
                tackCount++;
                if (tackAt < 0) begin
                    tackAt = n - 1;
                end
            end
            // First RAS fall of the cycle is ACTIVE, the later one precharge
            if (en && rasPrev && !RASn && !rowSeen) begin
                rowSeen   = 1'b1;
                rowVal    = CMA;
                bankVal   = {BANK1, BANK0};
                dmaBefore = sawDma;
            end
            if (en && casPrev && !CASn && rowSeen && !colSeen) begin
                colSeen    = 1'b1;
                colVal     = CMA;
                weAtCas    = WEn;
                dirAtCas   = cpuSide ? DBDIR : DRDDIR;
                lanesAtCas = {CUUBEn, CUMBEn, CLMBEn, CLLBEn};
            end
            if (colSeen && CRCSn && tail < 0) begin
                tail = 3;
            end else if (tail > 0) begin
                tail--;
            end
            rasPrev = RASn;
            casPrev = CASn;
        end
        assert (tail == 0) else begin
            $display("test %0d: RAM access did not finish within %0d cycles", testNum, limit);
            noteFailure();
        end
    endtask

    task automatic checkAddr(input logic cpuSide);
        checkVal("CMA row", 32'(rowVal), 32'(expRow));
        checkVal("CMA column", 32'(colVal), 32'(expCol));
        checkVal("{BANK1,BANK0}", 32'(bankVal), 32'(expBank));
        checkVal("byte enables", 32'(lanesAtCas), 32'(expLanes));
        // RnW or AWEn, both high on reads
        checkVal("WEn", 32'(weAtCas), 32'(!wr));
        checkVal(cpuSide ? "DBDIR" : "DRDDIR", 32'(dirAtCas), 32'(!wr));
    endtask

    task automatic runCpu();
        cpuStrobe(1'b0);
        watchRam(1'b1, 60);
        checkAddr(1'b1);
        checkVal("TACKn delay", 32'(tackAt), 32'd6);
        checkVal("TACKn count", 32'(tackCount), 32'd1);
    endtask

    task automatic runDma();
        fork
            agnusAccess(expBank, expStrobes);
            watchRam(1'b0, 60);
        join
        checkAddr(1'b0);
        checkVal("TACKn count", 32'(tackCount), 32'd0);
    endtask

    // CPU strobe lands just after the Agnus CAS
    task automatic runCollision();
        fork
            agnusAccess(2'b00, expStrobes);
            begin
                repeat (4) @(posedge CLK80);
                cpuStrobe(1'b0);
            end
            watchRam(1'b1, 120);
        join
        checkAddr(1'b1);
        checkVal("DMA before CPU", 32'(dmaBefore), 32'd1);
        checkVal("TACKn count", 32'(tackCount), 32'd1);
    endtask

    task automatic runReg();
        int         n;
        logic       asFell;
        logic [1:0] strobes;
        asFell    = 1'b0;
        strobes   = 2'b11;
        tackCount = 0;
        @(posedge CLK80);
        DBRn <= 1'b0;
        repeat (4) @(posedge CLK80);
        cpuStrobe(1'b1);
        for (n = 0; n < 40; n++) begin
            @(negedge CLK80);
            if (!ASn) begin
                asFell = 1'b1;
            end
        end
        assert (!asFell) else begin
            $display("test %0d: register cycle started while DBRn was low", testNum);
            noteFailure();
        end
        @(posedge CLK80);
        DBRn <= 1'b1;
        n = 0;
        while (ASn && n < 60) begin
            @(negedge CLK80);
            n++;
        end
        assert (!ASn) else begin
            $display("test %0d: ASn never went low after DBRn release", testNum);
            noteFailure();
        end
        checkVal("REGENn", 32'(REGENn), 32'd0);
        checkVal("VBENn", 32'(VBENn), 32'd0);
        // Strobes settle one clock into the frame
        while (!ASn && n < 60) begin
            strobes = {UDSn, LDSn};
            if (!TACKn) begin
                tackCount++;
            end
            @(negedge CLK80);
            n++;
        end
        assert (ASn) else begin
            $display("test %0d: register cycle did not end in time", testNum);
            noteFailure();
        end
        for (n = 0; n < 4; n++) begin
            if (!TACKn) begin
                tackCount++;
            end
            @(negedge CLK80);
        end
        checkVal("{UDSn,LDSn}", 32'(strobes), 32'(expStrobes));
        checkVal("TACKn count", 32'(tackCount), 32'd1);
    endtask

    ////////////////////
    initial begin
        int    t;
        int    base;
        string name;
        RESETn    <= 1'b0;
        RnW       <= 1'b1;
        TSn       <= 1'b1;
        DBRn      <= 1'b1;
        REGSPACEn <= 1'b1;
        RAMSPACEn <= 1'b1;
        AWEn      <= 1'b1;
        RAS0n     <= 1'b1;
        RAS1n     <= 1'b1;
        CASLn     <= 1'b1;
        CASUn     <= 1'b1;
        SIZ       <= 2'b00;
        A         <= '0;
        DRA       <= '0;
        totalErr = 0;
        testErr  = 0;
        testsRun = 0;
        testNum  = 0;
        void'($urandom(32'h80e73741));
        // Unloaded words keep a marker in the top half
        for (t = 0; t < 352; t++) begin
            caseMem[t] = {16'hFFFF, 16'(t)};
        end
        $readmemh("sim/chipBusCases.txt", caseMem);

        repeat (8) @(posedge CLK80);
        checkIdle(8);
        @(posedge CLK80);
        RESETn <= 1'b1;
        checkIdle(6);

        for (t = 0; t < 32; t++) begin
            base = t * 11;
            if (caseMem[base][31:16] == 16'hFFFF) begin
                break;
            end
            testNum    = t + 1;
            testErr    = 0;
            kind       = caseMem[base][3:0];
            addr       = caseMem[base + 1][20:0];
            siz        = caseMem[base + 2][1:0];
            wr         = caseMem[base + 3][0];
            draRow     = caseMem[base + 4][9:0];
            draCol     = caseMem[base + 5][9:0];
            expRow     = caseMem[base + 6][10:0];
            expCol     = caseMem[base + 7][10:0];
            expBank    = caseMem[base + 8][1:0];
            expLanes   = caseMem[base + 9][3:0];
            expStrobes = caseMem[base + 10][1:0];
            repeat ($urandom_range(6, 1)) @(posedge CLK80);
            case (kind)
                4'd0, 4'd1: begin
                    name = wr ? "cpu write" : "cpu read";
                    runCpu();
                end
                4'd2: begin
                    name = "register";
                    runReg();
                end
                4'd3: begin
                    name = "dma";
                    runDma();
                end
                4'd4: begin
                    name = "collision";
                    runCollision();
                end
                default: begin
                    name = "unknown";
                    $display("test %0d: unknown case kind %h", testNum, kind);
                    noteFailure();
                end
            endcase
            testsRun++;
            $display("test %0d %s addr %h: %s", testNum, name, addr,
                     testErr == 0 ? "ok" : "FAIL");
        end

        $display("%0d tests run, %0d checks with errors", testsRun, totalErr);
        if (totalErr == 0 && testsRun > 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
